// File: src/rot_macros.svh
`ifndef ROT_MACROS_SVH
`define ROT_MACROS_SVH

// sprite geometry.
`define ROT_IMAGE_SIZE 8
`define ROT_COOR_WIDTH 3

// pixel colour, zero is transparent.
`define ROT_COLOR_WIDTH 8

// binary angle, 512 per turn.
`define ROT_ANG_WIDTH 9

// cordic iterations.
`define ROT_STAGES 8

// fraction bits of centred coordinates.
`define ROT_FRAC_BITS 8

`endif

// File: src/sprite_pkg.sv
`default_nettype none
`include "rot_macros.svh"

package sprite_pkg;

    // one row or column index.
    typedef logic [`ROT_COOR_WIDTH-1:0] coor_t;

    // stored colour, zero reads as transparent.
    typedef logic [`ROT_COLOR_WIDTH-1:0] color_t;

    // row * size + column, i.e. {row, column}.
    typedef logic [2*`ROT_COOR_WIDTH-1:0] pix_addr_t;

endpackage

`default_nettype wire

// File: src/rot_pkg.sv
`default_nettype none
`include "rot_macros.svh"

package rot_pkg;

    // signed binary angle, quarter turn is 128.
    typedef logic signed [`ROT_ANG_WIDTH-1:0] angle_t;

    // centred coordinate in doubled units, ROT_FRAC_BITS fraction bits.
    typedef logic signed [15:0] fix_t;

    typedef enum logic [1:0] {
        IDLE,
        SCAN,
        HOLD
    } scan_state_t;

endpackage

`default_nettype wire

// File: src/raster_scanner.sv
`default_nettype none
`include "rot_macros.svh"

module raster_scanner (
    input  wire                    i_clk,
    input  wire                    i_rst_n,
    input  wire                    i_start,
    input  wire rot_pkg::angle_t   i_angle,
    output logic                   o_scan_valid,
    output sprite_pkg::coor_t      o_h,
    output sprite_pkg::coor_t      o_v,
    output rot_pkg::angle_t        o_angle,
    output logic                   o_last
);

    import sprite_pkg::*;
    import rot_pkg::*;

    scan_state_t state_q;
    coor_t       col_q;
    coor_t       row_q;
    logic        col_end;
    logic        frame_end;

    assign col_end   = (col_q == coor_t'(`ROT_IMAGE_SIZE - 1));
    assign frame_end = col_end && (row_q == coor_t'(`ROT_IMAGE_SIZE - 1));

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q      <= IDLE;
            col_q        <= '0;
            row_q        <= '0;
            o_scan_valid <= 1'b0;
            o_last       <= 1'b0;
        end else begin
            o_scan_valid <= 1'b0;
            o_last       <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (i_start) begin
                        state_q <= SCAN;
                        col_q   <= '0;
                        row_q   <= '0;
                    end
                end
                SCAN: begin
                    o_scan_valid <= 1'b1;
                    o_last       <= frame_end; // flags (7,7).
                    if (col_end) begin
                        col_q <= '0;
                        row_q <= row_q + 1'b1;
                    end else begin
                        col_q <= col_q + 1'b1;
                    end
                    if (frame_end) begin
                        state_q <= HOLD;
                    end
                end
                HOLD: begin
                    if (!i_start) begin
                        state_q <= IDLE; // start must drop first.
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state_q == IDLE && i_start) begin
            o_angle <= -i_angle; // inverse mapping.
        end
        if (state_q == SCAN) begin
            o_h <= col_q;
            o_v <= row_q;
        end
    end

endmodule

`default_nettype wire

// File: src/coord_rotator.sv
`default_nettype none
`include "rot_macros.svh"

module coord_rotator (
    input  wire                    i_clk,
    input  wire                    i_rst_n,
    input  wire                    i_valid,
    input  wire                    i_last,
    input  wire sprite_pkg::coor_t i_h,
    input  wire sprite_pkg::coor_t i_v,
    input  wire rot_pkg::angle_t   i_angle,
    output sprite_pkg::pix_addr_t  o_src_addr,
    output logic                   o_out_of_range,
    output logic                   o_valid,
    output logic                   o_last,
    output sprite_pkg::coor_t      o_h,
    output sprite_pkg::coor_t      o_v
);

    import sprite_pkg::*;
    import rot_pkg::*;

    // residual angle with ROT_FRAC_BITS extra fraction bits.
    typedef logic signed [15:0] zacc_t;

    function automatic zacc_t atan_lut(input int idx);
        case (idx)
            0:       atan_lut = zacc_t'(16384);
            1:       atan_lut = zacc_t'(9672);
            2:       atan_lut = zacc_t'(5110);
            3:       atan_lut = zacc_t'(2594);
            4:       atan_lut = zacc_t'(1302);
            5:       atan_lut = zacc_t'(652);
            6:       atan_lut = zacc_t'(326);
            7:       atan_lut = zacc_t'(163);
            default: atan_lut = zacc_t'(0);
        endcase
    endfunction

    logic signed [`ROT_COOR_WIDTH+1:0] h_c;
    logic signed [`ROT_COOR_WIDTH+1:0] v_c;
    fix_t   hx;
    fix_t   vy;
    angle_t ang_t;
    logic [1:0] quad;
    zacc_t  z_res;

    fix_t  x_s   [0:`ROT_STAGES];
    fix_t  y_s   [0:`ROT_STAGES];
    zacc_t z_s   [0:`ROT_STAGES];
    coor_t h_s   [0:`ROT_STAGES];
    coor_t v_s   [0:`ROT_STAGES];
    logic  vld_s [0:`ROT_STAGES];
    logic  lst_s [0:`ROT_STAGES];

    logic signed [31:0] x_gain;
    logic signed [31:0] y_gain;
    fix_t  x_k;
    fix_t  y_k;
    fix_t  x_src;
    fix_t  y_src;
    logic  oor;

    // 2*c - 7 gives odd values in -7..7.
    assign h_c = $signed({1'b0, i_h, 1'b0}) - (`ROT_IMAGE_SIZE - 1);
    assign v_c = $signed({1'b0, i_v, 1'b0}) - (`ROT_IMAGE_SIZE - 1);
    assign hx  = fix_t'(h_c) <<< `ROT_FRAC_BITS;
    assign vy  = fix_t'(v_c) <<< `ROT_FRAC_BITS;

    // nearest quarter turn and what is left of it.
    assign ang_t = i_angle + angle_t'(1 << (`ROT_ANG_WIDTH - 3));
    assign quad  = ang_t[`ROT_ANG_WIDTH-1:`ROT_ANG_WIDTH-2];
    assign z_res = zacc_t'({1'b0, ang_t[`ROT_ANG_WIDTH-3:0], `ROT_FRAC_BITS'(0)})
                 - zacc_t'(1 << (`ROT_ANG_WIDTH + `ROT_FRAC_BITS - 3));

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i <= `ROT_STAGES; i++) begin
                vld_s[i] <= 1'b0;
                lst_s[i] <= 1'b0;
            end
            o_valid <= 1'b0;
            o_last  <= 1'b0;
        end else begin
            vld_s[0] <= i_valid;
            lst_s[0] <= i_last;
            for (int i = 1; i <= `ROT_STAGES; i++) begin
                vld_s[i] <= vld_s[i-1];
                lst_s[i] <= lst_s[i-1];
            end
            o_valid <= vld_s[`ROT_STAGES];
            o_last  <= lst_s[`ROT_STAGES];
        end
    end

    always_ff @(posedge i_clk) begin
        case (quad)
            2'd0: begin x_s[0] <= hx;  y_s[0] <= vy;  end
            2'd1: begin x_s[0] <= -vy; y_s[0] <= hx;  end
            2'd2: begin x_s[0] <= -hx; y_s[0] <= -vy; end
            default: begin x_s[0] <= vy; y_s[0] <= -hx; end
        endcase
        z_s[0] <= z_res;
        h_s[0] <= i_h;
        v_s[0] <= i_v;
        for (int k = 0; k < `ROT_STAGES; k++) begin
            if (z_s[k] >= 0) begin
                x_s[k+1] <= x_s[k] - (y_s[k] >>> k);
                y_s[k+1] <= y_s[k] + (x_s[k] >>> k);
                z_s[k+1] <= z_s[k] - atan_lut(k);
            end else begin
                x_s[k+1] <= x_s[k] + (y_s[k] >>> k);
                y_s[k+1] <= y_s[k] - (x_s[k] >>> k);
                z_s[k+1] <= z_s[k] + atan_lut(k);
            end
            h_s[k+1] <= h_s[k];
            v_s[k+1] <= v_s[k];
        end
    end

    assign x_gain = 32'(x_s[`ROT_STAGES]) * 32'sd39798; // gain 0.60726 in q16.
    assign y_gain = 32'(y_s[`ROT_STAGES]) * 32'sd39798;
    assign x_k    = x_gain[31:16];
    assign y_k    = y_gain[31:16];

    // add 7, halve, round half up.
    assign x_src = (x_k + fix_t'(`ROT_IMAGE_SIZE << `ROT_FRAC_BITS)) >>> (`ROT_FRAC_BITS + 1);
    assign y_src = (y_k + fix_t'(`ROT_IMAGE_SIZE << `ROT_FRAC_BITS)) >>> (`ROT_FRAC_BITS + 1);

    assign oor = (x_src < 0) || (x_src > (`ROT_IMAGE_SIZE - 1))
              || (y_src < 0) || (y_src > (`ROT_IMAGE_SIZE - 1));

    always_ff @(posedge i_clk) begin
        o_src_addr     <= {coor_t'(y_src), coor_t'(x_src)};
        o_out_of_range <= oor;
        o_h            <= h_s[`ROT_STAGES];
        o_v            <= v_s[`ROT_STAGES];
    end

endmodule

`default_nettype wire

// File: src/sprite_ram.sv
`default_nettype none
`include "rot_macros.svh"

module sprite_ram (
    input  wire                        i_clk,
    input  wire                        i_wr_en,
    input  wire sprite_pkg::pix_addr_t i_wr_addr,
    input  wire sprite_pkg::color_t    i_wr_data,
    input  wire sprite_pkg::pix_addr_t i_rd_addr,
    output sprite_pkg::color_t         o_rd_data
);

    import sprite_pkg::*;

    color_t mem [0:`ROT_IMAGE_SIZE*`ROT_IMAGE_SIZE-1];

    // loaded only between frames.
    always_ff @(posedge i_clk) begin
        if (i_wr_en) begin
            mem[i_wr_addr] <= i_wr_data;
        end
    end

    always_ff @(posedge i_clk) begin
        o_rd_data <= mem[i_rd_addr]; // one cycle read.
    end

endmodule

`default_nettype wire

// File: src/pixel_shader.sv
`default_nettype none

module pixel_shader (
    input  wire                     i_clk,
    input  wire                     i_rst_n,
    input  wire                     i_valid,
    input  wire                     i_last,
    input  wire                     i_out_of_range,
    input  wire sprite_pkg::color_t i_color,
    input  wire sprite_pkg::coor_t  i_h,
    input  wire sprite_pkg::coor_t  i_v,
    output sprite_pkg::color_t      o_pixel,
    output logic                    o_opacity,
    output logic                    o_valid,
    output logic                    o_done,
    output sprite_pkg::coor_t       o_h,
    output sprite_pkg::coor_t       o_v
);

    import sprite_pkg::*;

    logic  valid_d;
    logic  last_d;
    logic  oor_d;
    coor_t h_d;
    coor_t v_d;
    logic  visible;

    assign visible = valid_d && !oor_d;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            valid_d   <= 1'b0;
            last_d    <= 1'b0;
            o_valid   <= 1'b0;
            o_done    <= 1'b0;
            o_opacity <= 1'b0;
        end else begin
            valid_d   <= i_valid; // lines up with ram data.
            last_d    <= i_last;
            o_valid   <= valid_d;
            o_done    <= valid_d && last_d;
            o_opacity <= visible && (i_color != '0);
        end
    end

    always_ff @(posedge i_clk) begin
        oor_d   <= i_out_of_range;
        h_d     <= i_h;
        v_d     <= i_v;
        o_pixel <= visible ? i_color : '0;
        o_h     <= h_d;
        o_v     <= v_d;
    end

endmodule

`default_nettype wire

// File: src/image_rotator.sv
`default_nettype none

module image_rotator (
    input  wire                        i_clk,
    input  wire                        i_rst_n,
    input  wire                        i_start,
    input  wire                        i_wr_en,
    input  wire rot_pkg::angle_t       i_angle,
    input  wire sprite_pkg::pix_addr_t i_wr_addr,
    input  wire sprite_pkg::color_t    i_wr_data,
    output sprite_pkg::color_t         o_pixel,
    output logic                       o_opacity,
    output sprite_pkg::coor_t          o_h,
    output sprite_pkg::coor_t          o_v,
    output logic                       o_valid,
    output logic                       o_done
);

    import sprite_pkg::*;
    import rot_pkg::*;

    logic      scan_valid;
    logic      scan_last;
    coor_t     scan_h;
    coor_t     scan_v;
    angle_t    scan_angle;

    pix_addr_t src_addr;
    logic      src_oor;
    logic      src_valid;
    logic      src_last;
    coor_t     src_h;
    coor_t     src_v;

    color_t    rd_color;

    raster_scanner u_scanner (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_start        (i_start),
        .i_angle        (i_angle),
        .o_scan_valid   (scan_valid),
        .o_h            (scan_h),
        .o_v            (scan_v),
        .o_angle        (scan_angle),
        .o_last         (scan_last)
    );

    coord_rotator u_rotator (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_valid        (scan_valid),
        .i_last         (scan_last),
        .i_h            (scan_h),
        .i_v            (scan_v),
        .i_angle        (scan_angle),
        .o_src_addr     (src_addr),
        .o_out_of_range (src_oor),
        .o_valid        (src_valid),
        .o_last         (src_last),
        .o_h            (src_h),
        .o_v            (src_v)
    );

    sprite_ram u_ram (
        .i_clk          (i_clk),
        .i_wr_en        (i_wr_en),
        .i_wr_addr      (i_wr_addr),
        .i_wr_data      (i_wr_data),
        .i_rd_addr      (src_addr),
        .o_rd_data      (rd_color)
    );

    pixel_shader u_shader (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_valid        (src_valid),
        .i_last         (src_last),
        .i_out_of_range (src_oor),
        .i_color        (rd_color),
        .i_h            (src_h),
        .i_v            (src_v),
        .o_pixel        (o_pixel),
        .o_opacity      (o_opacity),
        .o_valid        (o_valid),
        .o_done         (o_done),
        .o_h            (o_h),
        .o_v            (o_v)
    );

endmodule

`default_nettype wire

// File: bench/tb_image_rotator.sv
`default_nettype none

module tb_image_rotator;

    logic       i_clk;
    logic       i_rst_n;
    logic       i_start;
    logic       i_wr_en;
    logic [8:0] i_angle;
    logic [5:0] i_wr_addr;
    logic [7:0] i_wr_data;
    wire  [7:0] o_pixel;
    wire        o_opacity;
    wire  [2:0] o_h;
    wire  [2:0] o_v;
    wire        o_valid;
    wire        o_done;

    logic [7:0] sprite [0:63];
    int frame_ang [0:31];
    int s_ang [0:63];
    int s_h [0:63];
    int s_v [0:63];
    int s_pix [0:63];
    int s_op [0:63];
    int n_frames;
    int n_samples;
    int err_count;
    bit loaded;

    image_rotator u_dut (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_start(i_start), .i_wr_en(i_wr_en),
        .i_angle(i_angle), .i_wr_addr(i_wr_addr), .i_wr_data(i_wr_data),
        .o_pixel(o_pixel), .o_opacity(o_opacity), .o_h(o_h), .o_v(o_v),
        .o_valid(o_valid), .o_done(o_done)
    );

    always #10 i_clk = ~i_clk;

    task automatic report_error(input string msg);
        err_count++;
        $display("ERROR at time %0t: %s", $time, msg);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic load_sprite();
        for (int a = 0; a < 64; a++) begin
            @(negedge i_clk);
            i_wr_en   = 1'b1;
            i_wr_addr = a[5:0];
            i_wr_data = sprite[a];
        end
        @(negedge i_clk);
        i_wr_en = 1'b0;
    endtask

    // expected pixel for one output coordinate or -1 without a reference.
    function automatic int expected_pixel(input int ang, input int h, input int v,
                                          output int op);
        int norm;
        int sx;
        int sy;
        norm = ((ang % 512) + 512) % 512;
        op   = 0;
        if (norm % 128 != 0) begin
            for (int i = 0; i < n_samples; i++) begin
                if (s_ang[i] == ang && s_h[i] == h && s_v[i] == v) begin
                    op = s_op[i];
                    return s_pix[i];
                end
            end
            return -1;
        end
        case (norm)
            0:       begin sx = h;     sy = v;     end
            128:     begin sx = v;     sy = 7 - h; end
            256:     begin sx = 7 - h; sy = 7 - v; end
            default: begin sx = 7 - v; sy = h;     end
        endcase
        op = (sprite[sy*8+sx] != 8'd0) ? 1 : 0;
        return int'(sprite[sy*8+sx]);
    endfunction

    task automatic run_frame(input int ang);
        int idx;
        int exp_pix;
        int exp_op;
        @(negedge i_clk);
        i_start = 1'b1;
        i_angle = ang[8:0];
        // start is sampled at the next rising edge.
        for (int n = 1; n <= 100; n++) begin
            @(negedge i_clk);
            idx = n - 14;
            assert (o_valid == (idx >= 0 && idx < 64))
                else report_error($sformatf("angle %0d cycle %0d valid %b", ang, n, o_valid));
            assert (o_done == (idx == 63))
                else report_error($sformatf("angle %0d cycle %0d done %b", ang, n, o_done));
            if (idx >= 0 && idx < 64) begin
                assert (int'(o_h) == idx % 8 && int'(o_v) == idx / 8)
                    else report_error($sformatf("pixel %0d at (%0d,%0d)", idx, o_h, o_v));
                exp_pix = expected_pixel(ang, idx % 8, idx / 8, exp_op);
                if (exp_pix >= 0) begin
                    assert (int'(o_pixel) == exp_pix && int'(o_opacity) == exp_op)
                        else report_error($sformatf(
                            "angle %0d (%0d,%0d) got %h/%b exp %h/%0d", ang, idx % 8,
                            idx / 8, o_pixel, o_opacity, exp_pix, exp_op));
                end
            end
        end
        i_start = 1'b0;
        repeat (2) @(negedge i_clk);
    endtask

    initial begin
        int fd;
        int rc;
        int val;
        string hdr;
        i_clk = 1'b0;
        i_rst_n = 1'b0;
        i_start = 1'b0;
        i_wr_en = 1'b0;
        i_angle = '0;
        i_wr_addr = '0;
        i_wr_data = '0;
        err_count = 0;
        loaded = 1'b0;
        fd = $fopen("bench/rotator_stimulus.txt", "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file bench/rotator_stimulus.txt");
            $display("Test failures found");
            $fatal(1);
        end
        rc = $fgets(hdr, fd);
        for (int i = 0; i < 64; i++) begin
            rc = $fscanf(fd, "%h", val);
            sprite[i] = val[7:0];
        end
        rc = $fscanf(fd, "%d", n_frames);
        for (int i = 0; i < n_frames; i++) begin
            rc = $fscanf(fd, "%d", frame_ang[i]);
        end
        rc = $fscanf(fd, "%d", n_samples);
        for (int i = 0; i < n_samples; i++) begin
            rc = $fscanf(fd, "%d %d %d %h %d", s_ang[i], s_h[i], s_v[i], s_pix[i], s_op[i]);
        end
        $fclose(fd);
        loaded = 1'b1;
        repeat (10) @(negedge i_clk);
        i_rst_n = 1'b1;
        for (int n = 0; n < 5; n++) begin
            @(negedge i_clk);
            assert (!o_valid && !o_done && !o_opacity)
                else report_error("outputs active after reset");
        end
        load_sprite();
        for (int f = 0; f < n_frames; f++) begin
            run_frame(frame_ang[f]);
        end
        for (int a = 0; a < 64; a++) begin
            sprite[a] = sprite[a] + 8'd1; // new sprite between frames.
        end
        load_sprite();
        run_frame(0);
        if (err_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin
        wait (loaded);
        repeat ((n_frames + 1) * 100 + 200) @(posedge i_clk);
        $display("watchdog expired before the frames finished");
        $display("Test failures found");
        $fatal(1);
    end

endmodule

`default_nettype wire

// File: bench/rotator_stimulus.txt
sprite colours hex x64 row major, frame count, angles, sample count, samples: angle h v pixel opacity
00 11 12 13 14 15 16 00
21 22 00 24 25 26 27 28
31 32 33 34 3a 36 00 38
41 42 43 44 45 46 47 48
51 52 53 5c 55 00 57 58
61 62 63 64 65 66 67 68
71 00 73 74 75 76 77 78
81 82 83 84 85 86 87 00
5
0
128
256
-128
64
4
64 0 0 00 0
64 7 7 00 0
64 5 3 3a 1
64 5 6 57 1

// File: tb.f
+incdir+src
src/sprite_pkg.sv
src/rot_pkg.sv
src/raster_scanner.sv
src/coord_rotator.sv
src/sprite_ram.sv
src/pixel_shader.sv
src/image_rotator.sv
bench/tb_image_rotator.sv

// File: run.sh
#!/bin/bash
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f tb.f --top-module tb_image_rotator
./obj_dir/Vtb_image_rotator > sim.log 2>&1 || true
cat sim.log
if grep -q "All tests passed!" sim.log; then
    exit 0
else
    exit 1
fi
